//--- common/opfetch_config.svh
`ifndef OPFETCH_CONFIG_SVH
`define OPFETCH_CONFIG_SVH

// address and data width
// registers may hold addresses, so both stay equal
`define OPF_ADDR_W 32
`define OPF_DATA_W 32

// register number field width
`define OPF_REG_NUM_W 4

// registers addressable by one number field
`define OPF_REG_COUNT (1 << `OPF_REG_NUM_W)

// ip register is the last one
`define OPF_REG_IP (`OPF_REG_COUNT - 1)

`endif

//--- common/opfetch_pkg.sv
`default_nettype none

`include "opfetch_config.svh"

package opfetch_pkg;

  // data word, doubles as address
  typedef logic [`OPF_DATA_W-1:0] data_t;

  typedef logic [`OPF_REG_NUM_W-1:0] reg_num_t;

  // post inc/dec pair, decoded only
  typedef logic [1:0] mod_t;

  // opcode in bits 31:28
  typedef enum logic [3:0] {
    op_nop, op_mov, op_add, op_sub,
    op_and, op_or, op_xor, op_shl,
    op_shr, op_cmp, op_jmp, op_call,
    op_ret, op_ld, op_st, op_halt
  } opcode_e;

  // command word layout, msb first
  typedef struct packed {
    opcode_e  opcode;
    mod_t     cond_mod;
    mod_t     dst_mod;
    mod_t     src0_mod;
    mod_t     src1_mod;
    logic     cond_ptr;
    logic     dst_ptr;
    logic     src0_ptr;
    logic     src1_ptr;
    reg_num_t cond_num;
    reg_num_t dst_num;
    reg_num_t src0_num;
    reg_num_t src1_num;
  } cmd_word_t;

  typedef enum logic [1:0] {
    fetch_idle, fetch_read_req, fetch_read_wait_ack_low, fetch_hold
  } fetch_state_e;

  typedef enum logic [2:0] {
    opnd_idle, opnd_read_cond, opnd_read_src1, opnd_read_src0,
    opnd_out_req, opnd_out_wait_ack_low
  } operand_state_e;

  typedef enum logic [2:0] {
    rd_idle, rd_reg_req, rd_reg_release, rd_ptr_req, rd_ptr_release, rd_done
  } reader_state_e;

endpackage

`default_nettype wire

//--- common/mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "opfetch_config.svh"

// one four-phase read port
// rdata valid only while ack is high
interface mem_port_if;

  logic                   req;
  logic                   ack;
  logic [`OPF_ADDR_W-1:0] addr;
  opfetch_pkg::data_t     rdata;

  // stage side, addr stable from req rise to ack rise
  modport requester (output req, output addr, input ack, input rdata);

  // arbiter side
  modport responder (input req, input addr, output ack, output rdata);

endinterface

`default_nettype wire

//--- common/cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// command handoff between fetch and operand stage
// four-phase, word and address held from req rise to ack rise
interface cmd_if;

  logic                  req;
  logic                  ack;
  opfetch_pkg::cmd_word_t word;
  // address the word was read from
  opfetch_pkg::data_t    cmd_addr;

  // fetch stage
  modport source (output req, output word, output cmd_addr, input ack);

  // operand stage
  modport sink (input req, input word, input cmd_addr, output ack);

endinterface

`default_nettype wire

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "opfetch_config.svh"

module bus_arbiter (
  input  wire                     clk,
  input  wire                     rst,
  mem_port_if.responder           fetch_port,
  mem_port_if.responder           operand_port,
  output logic                    mem_req,
  output logic [`OPF_ADDR_W-1:0]  mem_addr,
  input  wire                     mem_ack,
  input  wire opfetch_pkg::data_t mem_rdata
);

  // external port owned for a whole four-phase cycle
  logic busy;
  // 1 when operand port owns the bus
  logic grant_opnd;
  // req of whoever holds the grant
  logic gnt_req;

  assign gnt_req = grant_opnd ? operand_port.req : fetch_port.req;

  // req passes through only once granted
  assign mem_req  = busy & gnt_req;
  assign mem_addr = grant_opnd ? operand_port.addr : fetch_port.addr;

  // ack straight back to granted side, same cycle
  // other side sees ack low
  assign fetch_port.ack   = busy & ~grant_opnd & mem_ack;
  assign operand_port.ack = busy & grant_opnd & mem_ack;

  // read data fans out, ack qualifies it
  assign fetch_port.rdata   = mem_rdata;
  assign operand_port.rdata = mem_rdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      grant_opnd <= 1'b0;
    end else if (!busy) begin
      // operand stage first when both wait
      if (operand_port.req) begin
        busy       <= 1'b1;
        grant_opnd <= 1'b1;
      end else if (fetch_port.req) begin
        busy       <= 1'b1;
        grant_opnd <= 1'b0;
      end
    end else if (!gnt_req && !mem_ack) begin
      // req and ack both back low, cycle closed
      busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hw/cmd_fetch/cmd_fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fetch_stage (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     start,
  input  wire opfetch_pkg::data_t start_ip,
  mem_port_if.requester           mem,
  cmd_if.source                   cmd
);

  opfetch_pkg::fetch_state_e state;

  // instruction pointer
  opfetch_pkg::data_t ip;

  logic mem_req_r;
  logic cmd_req_r;

  // word buffer holds one prefetched command
  logic                   word_full;
  opfetch_pkg::cmd_word_t word_r;
  opfetch_pkg::data_t     word_addr_r;

  // ip only moves at ack, so addr stays put during the read
  assign mem.req  = mem_req_r;
  assign mem.addr = ip;

  assign cmd.req      = cmd_req_r;
  assign cmd.word     = word_r;
  assign cmd.cmd_addr = word_addr_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= opfetch_pkg::fetch_idle;
      ip        <= '0;
      mem_req_r <= 1'b0;
      cmd_req_r <= 1'b0;
      word_full <= 1'b0;
    end else begin
      // offer buffered word, one cycle after mem req dropped
      if (word_full && !cmd_req_r && !cmd.ack) begin
        cmd_req_r <= 1'b1;
      end
      // taken by operand stage, buffer free again
      if (cmd_req_r && cmd.ack) begin
        cmd_req_r <= 1'b0;
        word_full <= 1'b0;
      end

      case (state)
        opfetch_pkg::fetch_idle: begin
          if (start) begin
            ip        <= start_ip;
            mem_req_r <= 1'b1;
            state     <= opfetch_pkg::fetch_read_req;
          end
        end
        opfetch_pkg::fetch_read_req: begin
          if (mem.ack) begin
            word_r      <= opfetch_pkg::cmd_word_t'(mem.rdata);
            word_addr_r <= ip;
            word_full   <= 1'b1;
            ip          <= ip + 1'b1;
            mem_req_r   <= 1'b0;
            state       <= opfetch_pkg::fetch_read_wait_ack_low;
          end
        end
        opfetch_pkg::fetch_read_wait_ack_low: begin
          // no new read before ack falls
          if (!mem.ack) begin
            state <= opfetch_pkg::fetch_hold;
          end
        end
        default: begin
          // back-pressure, next read only once buffer is empty
          if (!word_full) begin
            mem_req_r <= 1'b1;
            state     <= opfetch_pkg::fetch_read_req;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/operand_fetch/operand_reader.sv
`timescale 1ns/1ps
`default_nettype none

module operand_reader (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     go,
  input  wire                     is_ptr,
  input  wire                     skip_reg,
  input  wire opfetch_pkg::data_t reg_addr,
  output logic                    done,
  output opfetch_pkg::data_t      value,
  mem_port_if.requester           mem
);

  opfetch_pkg::reader_state_e state;

  logic               req_r;
  // second read through the register word pending
  logic               ptr_r;
  opfetch_pkg::data_t addr_r;

  assign mem.req  = req_r;
  assign mem.addr = addr_r;

  // one cycle pulse, value already latched
  assign done = (state == opfetch_pkg::rd_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= opfetch_pkg::rd_idle;
      req_r <= 1'b0;
      ptr_r <= 1'b0;
    end else begin
      case (state)
        opfetch_pkg::rd_idle: begin
          if (go) begin
            addr_r <= reg_addr;
            ptr_r  <= is_ptr;
            req_r  <= 1'b1;
            // ip case: reg_addr is already the pointer
            state  <= skip_reg ? opfetch_pkg::rd_ptr_req : opfetch_pkg::rd_reg_req;
          end
        end
        opfetch_pkg::rd_reg_req: begin
          if (mem.ack) begin
            value <= mem.rdata;
            req_r <= 1'b0;
            state <= opfetch_pkg::rd_reg_release;
          end
        end
        opfetch_pkg::rd_reg_release: begin
          if (!mem.ack) begin
            if (ptr_r) begin
              // register word is the operand address
              addr_r <= value;
              req_r  <= 1'b1;
              state  <= opfetch_pkg::rd_ptr_req;
            end else begin
              state <= opfetch_pkg::rd_done;
            end
          end
        end
        opfetch_pkg::rd_ptr_req: begin
          if (mem.ack) begin
            value <= mem.rdata;
            req_r <= 1'b0;
            state <= opfetch_pkg::rd_ptr_release;
          end
        end
        opfetch_pkg::rd_ptr_release: begin
          if (!mem.ack) begin
            state <= opfetch_pkg::rd_done;
          end
        end
        default: begin
          state <= opfetch_pkg::rd_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/operand_fetch/operand_fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "opfetch_config.svh"

module operand_fetch_stage (
  input  wire                         clk,
  input  wire                         rst,
  input  wire opfetch_pkg::data_t     base_addr_data,
  cmd_if.sink                         cmd,
  mem_port_if.requester               mem,
  output logic                        out_req,
  output opfetch_pkg::opcode_e        out_opcode,
  output opfetch_pkg::reg_num_t       out_dst_num,
  output opfetch_pkg::data_t          out_cond,
  output opfetch_pkg::data_t          out_src1,
  output opfetch_pkg::data_t          out_src0,
  output opfetch_pkg::data_t          out_cmd_addr,
  input  wire                         out_ack
);

  opfetch_pkg::operand_state_e state;
  logic                        ack_r;
  opfetch_pkg::cmd_word_t      word_r;

  // operand selected by current state
  opfetch_pkg::reg_num_t cur_num;
  logic                  cur_ptr;
  logic                  cur_is_ip;
  logic                  reuse_hit;
  opfetch_pkg::data_t    reuse_val;
  opfetch_pkg::data_t    ip_val;

  logic                  rdr_go;
  logic                  rdr_busy;
  logic                  rdr_done;
  opfetch_pkg::data_t    rdr_addr;
  opfetch_pkg::data_t    rdr_value;

  // operand finished this cycle, and its value
  logic                  opnd_fin;
  opfetch_pkg::data_t    opnd_val;

  assign cmd.ack     = ack_r;
  assign out_opcode  = word_r.opcode;
  assign out_dst_num = word_r.dst_num;

  // ip register reads as next command address
  assign ip_val    = out_cmd_addr + 1'b1;
  assign cur_is_ip = (cur_num == opfetch_pkg::reg_num_t'(`OPF_REG_IP));
  // ip pointer goes straight to the word after the command
  assign rdr_addr  = cur_is_ip ? ip_val : base_addr_data + opfetch_pkg::data_t'(cur_num);

  // operand mux and reuse match against earlier operands
  always_comb begin
    cur_num   = word_r.cond_num;
    cur_ptr   = word_r.cond_ptr;
    reuse_hit = 1'b0;
    reuse_val = out_cond;
    case (state)
      opfetch_pkg::opnd_read_src1: begin
        cur_num   = word_r.src1_num;
        cur_ptr   = word_r.src1_ptr;
        reuse_hit = (word_r.src1_num == word_r.cond_num) &&
                    (word_r.src1_ptr == word_r.cond_ptr);
      end
      opfetch_pkg::opnd_read_src0: begin
        cur_num = word_r.src0_num;
        cur_ptr = word_r.src0_ptr;
        // latest match first
        if ((word_r.src0_num == word_r.src1_num) && (word_r.src0_ptr == word_r.src1_ptr)) begin
          reuse_hit = 1'b1;
          reuse_val = out_src1;
        end else if ((word_r.src0_num == word_r.cond_num) &&
                     (word_r.src0_ptr == word_r.cond_ptr)) begin
          reuse_hit = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // reuse, ip plain or reader result
  always_comb begin
    opnd_fin = 1'b0;
    opnd_val = rdr_value;
    if (rdr_busy) begin
      opnd_fin = rdr_done;
    end else if (reuse_hit) begin
      opnd_fin = 1'b1;
      opnd_val = reuse_val;
    end else if (cur_is_ip && !cur_ptr) begin
      opnd_fin = 1'b1;
      opnd_val = ip_val;
    end
  end

  operand_reader i_operand_reader (
    .clk      (clk),
    .rst      (rst),
    .go       (rdr_go),
    .is_ptr   (cur_ptr),
    .skip_reg (cur_is_ip),
    .reg_addr (rdr_addr),
    .done     (rdr_done),
    .value    (rdr_value),
    .mem      (mem)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= opfetch_pkg::opnd_idle;
      ack_r    <= 1'b0;
      out_req  <= 1'b0;
      rdr_go   <= 1'b0;
      rdr_busy <= 1'b0;
    end else begin
      rdr_go <= 1'b0;
      if (opnd_fin) begin
        rdr_busy <= 1'b0;
      end
      case (state)
        opfetch_pkg::opnd_idle: begin
          if (!ack_r && cmd.req) begin
            word_r       <= cmd.word;
            out_cmd_addr <= cmd.cmd_addr;
            ack_r        <= 1'b1;
          end else if (ack_r && !cmd.req) begin
            // handoff closed, cond next cycle
            ack_r <= 1'b0;
            state <= opfetch_pkg::opnd_read_cond;
          end
        end
        opfetch_pkg::opnd_read_cond,
        opfetch_pkg::opnd_read_src1,
        opfetch_pkg::opnd_read_src0: begin
          if (opnd_fin) begin
            if (state == opfetch_pkg::opnd_read_cond) begin
              out_cond <= opnd_val;
              state    <= opfetch_pkg::opnd_read_src1;
            end else if (state == opfetch_pkg::opnd_read_src1) begin
              out_src1 <= opnd_val;
              state    <= opfetch_pkg::opnd_read_src0;
            end else begin
              out_src0 <= opnd_val;
              out_req  <= 1'b1;
              state    <= opfetch_pkg::opnd_out_req;
            end
          end else if (!rdr_busy) begin
            // needs memory, start the reader
            rdr_go   <= 1'b1;
            rdr_busy <= 1'b1;
          end
        end
        opfetch_pkg::opnd_out_req: begin
          // fields frozen until taken
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= opfetch_pkg::opnd_out_wait_ack_low;
          end
        end
        default: begin
          if (!out_ack) begin
            state <= opfetch_pkg::opnd_idle;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/opfetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "opfetch_config.svh"

module opfetch_top (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     start,
  input  wire opfetch_pkg::data_t start_ip,
  input  wire opfetch_pkg::data_t base_addr_data,
  output logic                    mem_req,
  output logic [`OPF_ADDR_W-1:0]  mem_addr,
  input  wire                     mem_ack,
  input  wire opfetch_pkg::data_t mem_rdata,
  output logic                    out_req,
  output opfetch_pkg::opcode_e    out_opcode,
  output opfetch_pkg::reg_num_t   out_dst_num,
  output opfetch_pkg::data_t      out_cond,
  output opfetch_pkg::data_t      out_src1,
  output opfetch_pkg::data_t      out_src0,
  output opfetch_pkg::data_t      out_cmd_addr,
  input  wire                     out_ack
);

  // per-stage memory ports, merged by the arbiter
  mem_port_if fetch_mem ();
  mem_port_if operand_mem ();

  // fetch to operand handoff
  cmd_if cmd_hand ();

  cmd_fetch_stage i_cmd_fetch_stage (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .start_ip (start_ip),
    .mem      (fetch_mem),
    .cmd      (cmd_hand)
  );

  operand_fetch_stage i_operand_fetch_stage (
    .clk            (clk),
    .rst            (rst),
    .base_addr_data (base_addr_data),
    .cmd            (cmd_hand),
    .mem            (operand_mem),
    .out_req        (out_req),
    .out_opcode     (out_opcode),
    .out_dst_num    (out_dst_num),
    .out_cond       (out_cond),
    .out_src1       (out_src1),
    .out_src0       (out_src0),
    .out_cmd_addr   (out_cmd_addr),
    .out_ack        (out_ack)
  );

  bus_arbiter i_bus_arbiter (
    .clk          (clk),
    .rst          (rst),
    .fetch_port   (fetch_mem),
    .operand_port (operand_mem),
    .mem_req      (mem_req),
    .mem_addr     (mem_addr),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata)
  );

endmodule

`default_nettype wire

//--- test/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

// four-phase read memory for the testbench
// ack delay per read comes from a table the testbench fills
module mem_model #(
  parameter int AW        = 10,
  parameter int REG_COUNT = 16
) (
  input  wire         clk,
  input  wire         rst,
  input  wire [31:0]  reg_base,
  input  wire         req,
  input  wire [31:0]  addr,
  output logic        ack,
  output logic [31:0] rdata,
  output logic [31:0] reg_reads
);

  // word store, index wraps on the low address bits
  logic [31:0] mem_arr [0:(1 << AW) - 1];

  // delay before each ack, 0 to 7 cycles
  logic [2:0] delay_tab [0:255];
  logic [7:0] delay_idx;
  logic [2:0] wait_cnt;

  // defined levels before the first clock edge
  initial begin
    ack       = 1'b0;
    rdata     = '0;
    reg_reads = '0;
  end

  always @(posedge clk) begin
    if (rst) begin
      ack       <= 1'b0;
      rdata     <= '0;
      reg_reads <= '0;
      delay_idx <= '0;
      wait_cnt  <= delay_tab[0];
    end else if (req && !ack) begin
      if (wait_cnt != 3'd0) begin
        wait_cnt <= wait_cnt - 3'd1;
      end else begin
        ack   <= 1'b1;
        rdata <= mem_arr[addr[AW-1:0]];
        // unsigned wrap also rejects addresses below the base
        if ((addr - reg_base) < REG_COUNT) begin
          reg_reads <= reg_reads + 32'd1;
        end
      end
    end else if (ack && !req) begin
      // cycle closed, arm delay for the next read
      ack       <= 1'b0;
      delay_idx <= delay_idx + 8'd1;
      wait_cnt  <= delay_tab[delay_idx + 8'd1];
    end
  end

endmodule

`default_nettype wire

//--- test/opfetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "opfetch_config.svh"

module opfetch_tb;

  // 6 tests x 8 commands x 7 reads x 12 cycles, about 4000, plus margin
  localparam int CYCLE_LIMIT = 6000;

  localparam logic [31:0] REG_BASE = 32'h0000_0200;
  // pointer targets, clear of the register area
  localparam logic [31:0] PTR_BASE = 32'h0000_0300;

  logic clk;
  logic rst;
  logic start;
  opfetch_pkg::data_t start_ip;
  opfetch_pkg::data_t base_addr_data;
  logic mem_req;
  logic [`OPF_ADDR_W-1:0] mem_addr;
  logic mem_ack;
  opfetch_pkg::data_t mem_rdata;
  logic out_req;
  logic out_ack;
  opfetch_pkg::opcode_e out_opcode;
  opfetch_pkg::reg_num_t out_dst_num;
  opfetch_pkg::data_t out_cond;
  opfetch_pkg::data_t out_src1;
  opfetch_pkg::data_t out_src0;
  opfetch_pkg::data_t out_cmd_addr;
  logic [31:0] reg_reads;

  // expected memory contents
  opfetch_pkg::data_t shadow [0:1023];
  // current program and its first address
  opfetch_pkg::cmd_word_t prog [0:15];
  opfetch_pkg::data_t prog_ip;

  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycles = 0;
  // register reads seen when the latest out_req rose
  int reads_at_req = 0;

  opfetch_top i_dut (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .start_ip       (start_ip),
    .base_addr_data (base_addr_data),
    .mem_req        (mem_req),
    .mem_addr       (mem_addr),
    .mem_ack        (mem_ack),
    .mem_rdata      (mem_rdata),
    .out_req        (out_req),
    .out_opcode     (out_opcode),
    .out_dst_num    (out_dst_num),
    .out_cond       (out_cond),
    .out_src1       (out_src1),
    .out_src0       (out_src0),
    .out_cmd_addr   (out_cmd_addr),
    .out_ack        (out_ack)
  );

  mem_model i_mem (
    .clk       (clk),
    .rst       (rst),
    .reg_base  (base_addr_data),
    .req       (mem_req),
    .addr      (mem_addr),
    .ack       (mem_ack),
    .rdata     (mem_rdata),
    .reg_reads (reg_reads)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic check_word(input string name, input opfetch_pkg::data_t exp,
                            input opfetch_pkg::data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_opcode(input string name, input opfetch_pkg::opcode_e exp,
                              input opfetch_pkg::opcode_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("[FAIL] %0t ns %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  function automatic opfetch_pkg::data_t fill_pattern(input opfetch_pkg::data_t a);
    return (a * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
  endfunction

  task automatic put_word(input opfetch_pkg::data_t a, input opfetch_pkg::data_t d);
    shadow[a[9:0]] = d;
    i_mem.mem_arr[a[9:0]] = d;
  endtask

  // operand rule: ip is command address plus one, else register word
  // pointer flag adds one more read through that value
  function automatic opfetch_pkg::data_t expect_operand(input logic [3:0] num,
      input logic ptr, input opfetch_pkg::data_t cmd_addr);
    opfetch_pkg::data_t v;
    if (num == `OPF_REG_IP) begin
      v = cmd_addr + 32'd1;
    end else begin
      v = shadow[(base_addr_data + num) & 32'h3FF];
    end
    if (ptr) begin
      v = shadow[v[9:0]];
    end
    return v;
  endfunction

  // register-area reads after reuse, ip never read as a register
  function automatic int reg_reads_of(input opfetch_pkg::cmd_word_t w);
    int n;
    n = 0;
    if (w.cond_num != `OPF_REG_IP) n++;
    if (w.src1_num != `OPF_REG_IP &&
        !(w.src1_num == w.cond_num && w.src1_ptr == w.cond_ptr)) n++;
    if (w.src0_num != `OPF_REG_IP &&
        !(w.src0_num == w.src1_num && w.src0_ptr == w.src1_ptr) &&
        !(w.src0_num == w.cond_num && w.src0_ptr == w.cond_ptr)) n++;
    return n;
  endfunction

  function automatic opfetch_pkg::cmd_word_t make_cmd(input logic [3:0] op,
      input logic [3:0] dst, input logic [3:0] cn, input logic cp,
      input logic [3:0] s1n, input logic s1p, input logic [3:0] s0n, input logic s0p);
    logic [7:0] mods;
    logic       dp;
    // modifiers and dst flag are decoded but unused
    mods = $urandom;
    dp   = $urandom;
    return {op, mods, cp, dp, s0p, s1p, cn, dst, s0n, s1n};
  endfunction

  task automatic init_memory();
    for (int a = 0; a < 1024; a++) begin
      put_word(a, fill_pattern(a));
    end
    // register words point into the target area
    for (int r = 0; r < 15; r++) begin
      put_word(REG_BASE + r, PTR_BASE + r * 5);
    end
    // slot of reg 15, must never be read
    put_word(REG_BASE + 15, 32'h0BAD_0F0F);
  endtask

  task automatic load_program(input int n);
    for (int k = 0; k < n; k++) begin
      put_word(prog_ip + k, prog[k]);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst     <= 1'b1;
    start   <= 1'b0;
    out_ack <= 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic start_run();
    @(posedge clk);
    start    <= 1'b1;
    start_ip <= prog_ip;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic check_fields(input opfetch_pkg::cmd_word_t w, input opfetch_pkg::data_t a);
    check_opcode("out_opcode", w.opcode, out_opcode);
    check_word("out_dst_num", {28'd0, w.dst_num}, {28'd0, out_dst_num});
    check_word("out_cond", expect_operand(w.cond_num, w.cond_ptr, a), out_cond);
    check_word("out_src1", expect_operand(w.src1_num, w.src1_ptr, a), out_src1);
    check_word("out_src0", expect_operand(w.src0_num, w.src0_ptr, a), out_src0);
    check_word("out_cmd_addr", a, out_cmd_addr);
  endtask

  // one output handshake for command k, random hold before ack
  task automatic take_and_check(input int k, input int hold_max);
    opfetch_pkg::cmd_word_t w;
    opfetch_pkg::data_t     a;
    int                     hold;
    w    = prog[k];
    a    = prog_ip + k;
    hold = $urandom % (hold_max + 1);
    @(negedge clk);
    while (out_req !== 1'b1) @(negedge clk);
    reads_at_req = reg_reads;
    check_fields(w, a);
    // fields must hold while unacknowledged
    repeat (hold) begin
      @(negedge clk);
      if (out_req !== 1'b1) report_problem("out_req fell before out_ack");
      check_fields(w, a);
    end
    @(posedge clk);
    out_ack <= 1'b1;
    @(negedge clk);
    while (out_req !== 1'b0) @(negedge clk);
    @(posedge clk);
    out_ack <= 1'b0;
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err0);
    end
  endtask

  task automatic test_plain();
    int err0;
    err0 = errors;
    apply_reset();
    init_memory();
    prog_ip = 32'h100;
    // three distinct registers per command
    for (int k = 0; k < 8; k++) begin
      prog[k] = make_cmd(k + 1, k + 2, k % 15, 1'b0, (k + 5) % 15, 1'b0,
                         (k + 10) % 15, 1'b0);
    end
    load_program(8);
    start_run();
    for (int k = 0; k < 8; k++) take_and_check(k, 3);
    finish_test("plain operands", err0);
  endtask

  task automatic test_pointer();
    int err0;
    err0 = errors;
    apply_reset();
    init_memory();
    prog_ip = 32'h120;
    for (int k = 0; k < 8; k++) begin
      prog[k] = make_cmd(k + 8, 15 - k, k % 15, 1'b1, (k + 5) % 15, 1'b1,
                         (k + 10) % 15, 1'b1);
    end
    load_program(8);
    start_run();
    for (int k = 0; k < 8; k++) take_and_check(k, 3);
    finish_test("pointer operands", err0);
  endtask

  task automatic test_ip();
    int err0;
    err0 = errors;
    apply_reset();
    init_memory();
    prog_ip = 32'h140;
    // ip pointer reads the next program word
    prog[0] = make_cmd(4'd10, 4'd1, 4'd15, 1'b0, 4'd15, 1'b1, 4'd2, 1'b0);
    prog[1] = make_cmd(4'd11, 4'd2, 4'd3, 1'b1, 4'd15, 1'b0, 4'd15, 1'b1);
    prog[2] = make_cmd(4'd12, 4'd3, 4'd15, 1'b1, 4'd4, 1'b0, 4'd15, 1'b0);
    prog[3] = make_cmd(4'd13, 4'd4, 4'd15, 1'b0, 4'd15, 1'b0, 4'd15, 1'b1);
    load_program(4);
    start_run();
    for (int k = 0; k < 4; k++) take_and_check(k, 3);
    finish_test("ip register", err0);
  endtask

  task automatic test_reuse();
    int err0;
    int exp_reads;
    err0      = errors;
    exp_reads = 0;
    apply_reset();
    init_memory();
    prog_ip = 32'h160;
    prog[0] = make_cmd(4'd1, 4'd0, 4'd3, 1'b0, 4'd3, 1'b0, 4'd3, 1'b0);
    prog[1] = make_cmd(4'd2, 4'd1, 4'd2, 1'b0, 4'd5, 1'b0, 4'd2, 1'b0);
    prog[2] = make_cmd(4'd3, 4'd2, 4'd4, 1'b1, 4'd4, 1'b1, 4'd7, 1'b0);
    prog[3] = make_cmd(4'd4, 4'd3, 4'd6, 1'b0, 4'd9, 1'b0, 4'd9, 1'b0);
    // same number, flags differ, only src0 reuses cond
    prog[4] = make_cmd(4'd5, 4'd4, 4'd1, 1'b1, 4'd1, 1'b0, 4'd1, 1'b1);
    prog[5] = make_cmd(4'd6, 4'd5, 4'd15, 1'b0, 4'd15, 1'b0, 4'd15, 1'b0);
    prog[6] = make_cmd(4'd7, 4'd6, 4'd8, 1'b0, 4'd8, 1'b1, 4'd8, 1'b0);
    prog[7] = make_cmd(4'd9, 4'd7, 4'd15, 1'b1, 4'd0, 1'b0, 4'd15, 1'b1);
    for (int k = 0; k < 8; k++) exp_reads += reg_reads_of(prog[k]);
    load_program(8);
    start_run();
    for (int k = 0; k < 8; k++) take_and_check(k, 3);
    check_count("register area reads", exp_reads, reads_at_req);
    finish_test("operand reuse", err0);
  endtask

  task automatic test_backpressure();
    int          err0;
    logic [31:0] r;
    err0 = errors;
    apply_reset();
    init_memory();
    prog_ip = 32'h1C0;
    for (int k = 0; k < 8; k++) begin
      r       = $urandom;
      prog[k] = make_cmd(r[3:0], r[7:4], r[11:8], r[12], r[16:13], r[17], r[21:18], r[22]);
    end
    load_program(8);
    start_run();
    // long holds, order shows in cmd address and opcode
    for (int k = 0; k < 8; k++) take_and_check(k, 7);
    finish_test("back-pressure and order", err0);
  endtask

  task automatic test_reset_mid_run();
    int err0;
    err0 = errors;
    apply_reset();
    init_memory();
    prog_ip = 32'h100;
    for (int k = 0; k < 4; k++) begin
      prog[k] = make_cmd(k + 3, k, k, 1'b0, k + 4, 1'b1, k + 8, 1'b0);
    end
    load_program(4);
    start_run();
    take_and_check(0, 2);
    take_and_check(1, 2);
    // third command left waiting for out_ack
    @(negedge clk);
    while (out_req !== 1'b1) @(negedge clk);
    apply_reset();
    @(negedge clk);
    if (out_req !== 1'b0) report_problem("out_req still high after reset");
    // restart, then cut the first command read short
    start_run();
    @(negedge clk);
    while (mem_req !== 1'b1) @(negedge clk);
    apply_reset();
    @(negedge clk);
    if (mem_req !== 1'b0) report_problem("mem_req still high after reset");
    prog_ip = 32'h180;
    for (int k = 0; k < 3; k++) begin
      prog[k] = make_cmd(14 - k, k + 9, k + 6, 1'b1, 15, 1'b0, k + 1, 1'b0);
    end
    load_program(3);
    start_run();
    for (int k = 0; k < 3; k++) take_and_check(k, 2);
    finish_test("reset mid-run", err0);
  endtask

  initial begin
    void'($urandom(32'h1776));
    rst            = 1'b1;
    start          = 1'b0;
    start_ip       = '0;
    base_addr_data = REG_BASE;
    out_ack        = 1'b0;
    for (int i = 0; i < 256; i++) begin
      i_mem.delay_tab[i] = $urandom % 8;
    end
    test_plain();
    test_pointer();
    test_ip();
    test_reuse();
    test_backpressure();
    test_reset_mid_run();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- opfetch.f
+incdir+common
common/opfetch_pkg.sv
common/mem_port_if.sv
common/cmd_if.sv
hw/bus_arbiter.sv
hw/cmd_fetch/cmd_fetch_stage.sv
hw/operand_fetch/operand_reader.sv
hw/operand_fetch/operand_fetch_stage.sv
hw/opfetch_top.sv
test/mem_model.sv
test/opfetch_tb.sv
